//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -f sources.f --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/bus_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
  input  logic            clk,
  input  logic            reset_i,
  // fetch side
  input  logic            f_req_i,
  input  core_pkg::xlen_t f_addr_i,
  output logic            f_done_o,
  // data side
  input  logic            d_req_i,
  input  logic            d_write_i,
  input  core_pkg::xlen_t d_addr_i,
  input  core_pkg::xlen_t d_wdata_i,
  output logic            d_done_o,
  output core_pkg::xlen_t rdata_o,
  // apb master
  output logic            psel_o,
  output logic            penable_o,
  output logic            pwrite_o,
  output core_pkg::xlen_t paddr_o,
  output core_pkg::xlen_t pwdata_o,
  input  core_pkg::xlen_t prdata_i,
  input  logic            pready_i
);

  typedef enum logic [1:0] {
    AB_IDLE,
    AB_SETUP,
    AB_ACCESS
  } ab_state_e;

  ab_state_e state_q;
  logic      owner_d_q;
  logic      busy;
  logic      xfer_done;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q   <= AB_IDLE;
      owner_d_q <= 1'b0;
    end else begin
      case (state_q)
        AB_IDLE: begin
          // data side wins, owner locked until done
          if (d_req_i || f_req_i) begin
            state_q   <= AB_SETUP;
            owner_d_q <= d_req_i;
          end
        end
        AB_SETUP: state_q <= AB_ACCESS;
        AB_ACCESS: begin
          if (pready_i) begin
            state_q <= AB_IDLE;
          end
        end
        default: state_q <= AB_IDLE;
      endcase
    end
  end

  assign busy      = (state_q != AB_IDLE);
  assign xfer_done = (state_q == AB_ACCESS) && pready_i;

  assign psel_o    = busy;
  assign penable_o = (state_q == AB_ACCESS);
  assign pwrite_o  = busy && owner_d_q && d_write_i;
  assign paddr_o   = owner_d_q ? d_addr_i : f_addr_i;
  assign pwdata_o  = d_wdata_i;

  assign d_done_o  = xfer_done && owner_d_q;
  assign f_done_o  = xfer_done && !owner_d_q;
  assign rdata_o   = prdata_i;

endmodule

`default_nettype wire

//--- design/core_pkg.sv
`default_nettype none

package core_pkg;

  // ====================
  // basic types
  // ====================
  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_e;

  // register write-back source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_PC4,
    WB_IMM,
    WB_LOAD
  } wb_sel_e;

  // ====================
  // rv32i opcodes
  // ====================
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // reset values
  localparam xlen_t RESET_PC  = 32'h0000_0000;
  localparam xlen_t NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

endpackage

`default_nettype wire

//--- design/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
  input  core_pkg::xlen_t   pc_i,
  input  core_pkg::xlen_t   rdata1_i,
  input  core_pkg::xlen_t   rdata2_i,
  input  core_pkg::xlen_t   imm_i,
  input  core_pkg::alu_op_e alu_op_i,
  input  logic              use_imm_i,
  input  logic              branch_i,
  input  logic              branch_ne_i,
  input  logic              jal_i,
  input  core_pkg::wb_sel_e wb_sel_i,
  input  core_pkg::xlen_t   load_data_i,
  output core_pkg::xlen_t   alu_result_o,
  output core_pkg::xlen_t   next_pc_o,
  output core_pkg::xlen_t   wb_data_o,
  output logic              redirect_o
);

  core_pkg::xlen_t op_b;
  core_pkg::xlen_t pc_plus4;
  logic            take;

  assign op_b     = use_imm_i ? imm_i : rdata2_i;
  assign pc_plus4 = pc_i + 32'd4;

  // ====================
  // alu
  // ====================
  always_comb begin
    case (alu_op_i)
      core_pkg::ALU_SUB:    alu_result_o = rdata1_i - op_b;
      core_pkg::ALU_AND:    alu_result_o = rdata1_i & op_b;
      core_pkg::ALU_OR:     alu_result_o = rdata1_i | op_b;
      core_pkg::ALU_XOR:    alu_result_o = rdata1_i ^ op_b;
      core_pkg::ALU_SLT:    alu_result_o = {31'b0, $signed(rdata1_i) < $signed(op_b)};
      core_pkg::ALU_SLL:    alu_result_o = rdata1_i << op_b[4:0];
      core_pkg::ALU_SRL:    alu_result_o = rdata1_i >> op_b[4:0];
      core_pkg::ALU_SRA:    alu_result_o = $signed(rdata1_i) >>> op_b[4:0];
      core_pkg::ALU_PASS_B: alu_result_o = op_b;
      default:              alu_result_o = rdata1_i + op_b;
    endcase
  end

  // beq/bne compare the raw register values
  assign take       = jal_i | (branch_i & ((rdata1_i == rdata2_i) ^ branch_ne_i));
  assign next_pc_o  = take ? (pc_i + imm_i) : pc_plus4;
  assign redirect_o = take;

  always_comb begin
    case (wb_sel_i)
      core_pkg::WB_PC4:  wb_data_o = pc_plus4;
      core_pkg::WB_IMM:  wb_data_o = imm_i;
      core_pkg::WB_LOAD: wb_data_o = load_data_i;
      default:           wb_data_o = alu_result_o;
    endcase
  end

endmodule

`default_nettype wire

//--- design/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
  input  logic            clk,
  input  logic            reset_i,
  output logic            fetch_req_o,
  output core_pkg::xlen_t fetch_addr_o,
  input  logic            fetch_done_i,
  input  core_pkg::xlen_t fetch_data_i,
  output core_pkg::xlen_t instr_o,
  output core_pkg::xlen_t pc_o,
  input  core_pkg::xlen_t next_pc_i,
  input  logic            redirect_i,
  input  logic            mem_op_i,
  input  logic            mem_done_i,
  output logic            retire_o
);

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_ISSUE,
    ST_MEM
  } state_e;

  state_e          state_q;
  core_pkg::xlen_t pc_q;
  core_pkg::xlen_t ir_q;
  core_pkg::xlen_t req_addr_q;  // also the tag of the prefetched word
  core_pkg::xlen_t pf_data_q;
  logic            req_q;
  logic            pf_q;
  logic            pf_valid_q;
  logic            pf_match;

  assign fetch_req_o  = req_q;
  assign fetch_addr_o = req_addr_q;
  assign instr_o      = ir_q;
  assign pc_o         = pc_q;
  assign retire_o     = ((state_q == ST_ISSUE) && !mem_op_i) ||
                        ((state_q == ST_MEM) && mem_done_i);
  assign pf_match     = !redirect_i && (req_addr_q == next_pc_i);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q    <= ST_FETCH;
      pc_q       <= core_pkg::RESET_PC;
      ir_q       <= core_pkg::NOP_INSTR;
      req_q      <= 1'b0;
      pf_q       <= 1'b0;
      pf_valid_q <= 1'b0;
    end else begin
      // ====================
      // bus completion
      // ====================
      if (fetch_done_i) begin
        req_q <= 1'b0;
        if (pf_q) begin
          pf_valid_q <= 1'b1;
          pf_data_q  <= fetch_data_i;
        end else begin
          ir_q    <= fetch_data_i;
          state_q <= ST_ISSUE;
        end
      end
      // ====================
      // sequencer
      // ====================
      case (state_q)
        ST_FETCH: begin
          if (!req_q) begin
            req_q      <= 1'b1;
            req_addr_q <= pc_q;
            pf_q       <= 1'b0;
          end
        end
        ST_ISSUE: begin
          if (mem_op_i) begin
            // prefetch the next word while the load/store runs
            state_q    <= ST_MEM;
            req_q      <= 1'b1;
            req_addr_q <= pc_q + 32'd4;
            pf_q       <= 1'b1;
          end else begin
            pc_q    <= next_pc_i;
            ir_q    <= core_pkg::NOP_INSTR;
            state_q <= ST_FETCH;
          end
        end
        ST_MEM: begin
          if (mem_done_i) begin
            pc_q       <= next_pc_i;
            pf_valid_q <= 1'b0;
            if (pf_valid_q && pf_match) begin
              ir_q    <= pf_data_q;
              state_q <= ST_ISSUE;
            end else begin
              ir_q    <= core_pkg::NOP_INSTR;
              state_q <= ST_FETCH;
              // an in-flight prefetch becomes the demand fetch
              if (req_q && pf_match) begin
                pf_q <= 1'b0;
              end
            end
          end
        end
        default: state_q <= ST_FETCH;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
  input  core_pkg::xlen_t     instr_i,
  output core_pkg::reg_addr_t rs1_o,
  output core_pkg::reg_addr_t rs2_o,
  output core_pkg::reg_addr_t rd_o,
  output core_pkg::xlen_t     imm_o,
  output core_pkg::alu_op_e   alu_op_o,
  output logic                use_imm_o,
  output logic                reg_write_o,
  output core_pkg::wb_sel_e   wb_sel_o,
  output logic                mem_read_o,
  output logic                mem_write_o,
  output logic                branch_o,
  output logic                branch_ne_o,
  output logic                jal_o
);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic              funct7_5;
  core_pkg::alu_op_e f3_op;

  assign opcode   = instr_i[6:0];
  assign funct3   = instr_i[14:12];
  assign funct7_5 = instr_i[30];
  assign rs1_o    = instr_i[19:15];
  assign rs2_o    = instr_i[24:20];
  assign rd_o     = instr_i[11:7];

  // alu op from funct3, sub only exists for register form
  always_comb begin
    case (funct3)
      3'b000:  f3_op = (funct7_5 && opcode == core_pkg::OPC_OP) ? core_pkg::ALU_SUB
                                                                : core_pkg::ALU_ADD;
      3'b001:  f3_op = core_pkg::ALU_SLL;
      3'b010:  f3_op = core_pkg::ALU_SLT;
      3'b100:  f3_op = core_pkg::ALU_XOR;
      3'b101:  f3_op = funct7_5 ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      3'b110:  f3_op = core_pkg::ALU_OR;
      default: f3_op = core_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    imm_o       = '0;
    alu_op_o    = core_pkg::ALU_ADD;
    use_imm_o   = 1'b0;
    reg_write_o = 1'b0;
    wb_sel_o    = core_pkg::WB_ALU;
    mem_read_o  = 1'b0;
    mem_write_o = 1'b0;
    branch_o    = 1'b0;
    branch_ne_o = 1'b0;
    jal_o       = 1'b0;
    case (opcode)
      core_pkg::OPC_OP: begin
        alu_op_o    = f3_op;
        reg_write_o = (funct3 != 3'b011);
      end
      core_pkg::OPC_OP_IMM: begin
        // no shift-immediates and no sltiu
        imm_o       = {{20{instr_i[31]}}, instr_i[31:20]};
        alu_op_o    = f3_op;
        use_imm_o   = 1'b1;
        reg_write_o = (funct3 != 3'b011) && (funct3[1:0] != 2'b01);
      end
      core_pkg::OPC_LUI: begin
        imm_o       = {instr_i[31:12], 12'b0};
        alu_op_o    = core_pkg::ALU_PASS_B;
        use_imm_o   = 1'b1;
        reg_write_o = 1'b1;
        wb_sel_o    = core_pkg::WB_IMM;
      end
      core_pkg::OPC_LOAD: begin
        imm_o       = {{20{instr_i[31]}}, instr_i[31:20]};
        use_imm_o   = 1'b1;
        mem_read_o  = (funct3 == 3'b010);
        reg_write_o = (funct3 == 3'b010);
        wb_sel_o    = core_pkg::WB_LOAD;
      end
      core_pkg::OPC_STORE: begin
        imm_o       = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
        use_imm_o   = 1'b1;
        mem_write_o = (funct3 == 3'b010);
      end
      core_pkg::OPC_BRANCH: begin
        imm_o       = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
        branch_o    = (funct3[2:1] == 2'b00);
        branch_ne_o = funct3[0];
      end
      core_pkg::OPC_JAL: begin
        imm_o       = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};
        jal_o       = 1'b1;
        reg_write_o = 1'b1;
        wb_sel_o    = core_pkg::WB_PC4;
      end
      default: begin
        // unknown opcode, behaves as a nop
        reg_write_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/load_store_unit.sv
`timescale 1ns/1ns
`default_nettype none

module load_store_unit (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            start_i,
  input  logic            mem_read_i,
  input  logic            mem_write_i,
  input  core_pkg::xlen_t addr_i,
  input  core_pkg::xlen_t wdata_i,
  output logic            req_o,
  output logic            req_write_o,
  output core_pkg::xlen_t req_addr_o,
  output core_pkg::xlen_t req_wdata_o,
  input  logic            req_done_i,
  input  core_pkg::xlen_t req_rdata_i,
  output logic            done_o,
  output core_pkg::xlen_t load_data_o
);

  logic            busy_q;
  logic            read_q;
  logic            write_q;
  core_pkg::xlen_t addr_q;
  core_pkg::xlen_t wdata_q;
  core_pkg::xlen_t load_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy_q  <= 1'b0;
      read_q  <= 1'b0;
      write_q <= 1'b0;
    end else if (!busy_q && start_i) begin
      busy_q  <= 1'b1;
      read_q  <= mem_read_i;
      write_q <= mem_write_i;
    end else if (busy_q && req_done_i) begin
      busy_q <= 1'b0;
    end
  end

  // payload, word aligned
  always_ff @(posedge clk) begin
    if (!busy_q && start_i) begin
      addr_q  <= {addr_i[31:2], 2'b00};
      wdata_q <= wdata_i;
    end
    if (req_done_i && read_q) begin
      load_q <= req_rdata_i;
    end
  end

  assign req_o       = busy_q;
  assign req_write_o = write_q;
  assign req_addr_o  = addr_q;
  assign req_wdata_o = wdata_q;
  assign done_o      = busy_q & req_done_i;
  // bypass so a load can retire in its done cycle
  assign load_data_o = req_done_i ? req_rdata_i : load_q;

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic                clk,
  input  logic                reset_i,
  input  core_pkg::reg_addr_t raddr1_i,
  input  core_pkg::reg_addr_t raddr2_i,
  output core_pkg::xlen_t     rdata1_o,
  output core_pkg::xlen_t     rdata2_o,
  input  logic                we_i,
  input  core_pkg::reg_addr_t waddr_i,
  input  core_pkg::xlen_t     wdata_i
);

  core_pkg::xlen_t regs [32];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 is hardwired, whatever was written there
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

//--- design/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core (
  input  logic            clk,
  input  logic            reset_i,
  output logic            psel_o,
  output logic            penable_o,
  output logic            pwrite_o,
  output core_pkg::xlen_t paddr_o,
  output core_pkg::xlen_t pwdata_o,
  input  core_pkg::xlen_t prdata_i,
  input  logic            pready_i
);

  core_pkg::xlen_t     fetch_addr, bus_rdata, instr, pc, next_pc, imm;
  core_pkg::xlen_t     rdata1, rdata2, alu_result, wb_data, load_data;
  core_pkg::xlen_t     lsu_addr, lsu_wdata;
  core_pkg::reg_addr_t rs1, rs2, rd;
  core_pkg::alu_op_e   alu_op;
  core_pkg::wb_sel_e   wb_sel;
  logic                fetch_req, fetch_done, redirect, retire;
  logic                mem_op, mem_done, reg_write, rf_we, use_imm;
  logic                mem_read, mem_write, branch, branch_ne, jal;
  logic                lsu_req, lsu_write, lsu_done;

  assign mem_op = mem_read | mem_write;
  assign rf_we  = retire & reg_write;

  fetch_unit u_fetch_unit (
    .clk(clk), .reset_i(reset_i),
    .fetch_req_o(fetch_req), .fetch_addr_o(fetch_addr),
    .fetch_done_i(fetch_done), .fetch_data_i(bus_rdata),
    .instr_o(instr), .pc_o(pc), .next_pc_i(next_pc), .redirect_i(redirect),
    .mem_op_i(mem_op), .mem_done_i(mem_done), .retire_o(retire)
  );

  instr_decoder u_instr_decoder (
    .instr_i(instr), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm),
    .alu_op_o(alu_op), .use_imm_o(use_imm), .reg_write_o(reg_write), .wb_sel_o(wb_sel),
    .mem_read_o(mem_read), .mem_write_o(mem_write),
    .branch_o(branch), .branch_ne_o(branch_ne), .jal_o(jal)
  );

  reg_file u_reg_file (
    .clk(clk), .reset_i(reset_i),
    .raddr1_i(rs1), .raddr2_i(rs2), .rdata1_o(rdata1), .rdata2_o(rdata2),
    .we_i(rf_we), .waddr_i(rd), .wdata_i(wb_data)
  );

  execute_unit u_execute_unit (
    .pc_i(pc), .rdata1_i(rdata1), .rdata2_i(rdata2), .imm_i(imm),
    .alu_op_i(alu_op), .use_imm_i(use_imm),
    .branch_i(branch), .branch_ne_i(branch_ne), .jal_i(jal),
    .wb_sel_i(wb_sel), .load_data_i(load_data),
    .alu_result_o(alu_result), .next_pc_o(next_pc), .wb_data_o(wb_data),
    .redirect_o(redirect)
  );

  load_store_unit u_load_store_unit (
    .clk(clk), .reset_i(reset_i),
    .start_i(mem_op), .mem_read_i(mem_read), .mem_write_i(mem_write),
    .addr_i(alu_result), .wdata_i(rdata2),
    .req_o(lsu_req), .req_write_o(lsu_write), .req_addr_o(lsu_addr),
    .req_wdata_o(lsu_wdata), .req_done_i(lsu_done), .req_rdata_i(bus_rdata),
    .done_o(mem_done), .load_data_o(load_data)
  );

  bus_arbiter u_bus_arbiter (
    .clk(clk), .reset_i(reset_i),
    .f_req_i(fetch_req), .f_addr_i(fetch_addr), .f_done_o(fetch_done),
    .d_req_i(lsu_req), .d_write_i(lsu_write), .d_addr_i(lsu_addr),
    .d_wdata_i(lsu_wdata), .d_done_o(lsu_done), .rdata_o(bus_rdata),
    .psel_o(psel_o), .penable_o(penable_o), .pwrite_o(pwrite_o),
    .paddr_o(paddr_o), .pwdata_o(pwdata_o), .prdata_i(prdata_i), .pready_i(pready_i)
  );

endmodule

`default_nettype wire

//--- sources.f
+incdir+tests
design/core_pkg.sv
design/reg_file.sv
design/instr_decoder.sv
design/execute_unit.sv
design/fetch_unit.sv
design/load_store_unit.sv
design/bus_arbiter.sv
design/rv_core.sv
tests/tb_rv_core.sv

//--- tests/rv_model.svh
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// ====================
// instruction encoders
// ====================
function automatic core_pkg::xlen_t enc_r(input logic [6:0] f7, input core_pkg::reg_addr_t rs2,
                                          input core_pkg::reg_addr_t rs1, input logic [2:0] f3,
                                          input core_pkg::reg_addr_t rd);
  return {f7, rs2, rs1, f3, rd, core_pkg::OPC_OP};
endfunction

function automatic core_pkg::xlen_t enc_i(input logic [11:0] imm, input core_pkg::reg_addr_t rs1,
                                          input logic [2:0] f3, input core_pkg::reg_addr_t rd,
                                          input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

// stores always use x1 as the base
function automatic core_pkg::xlen_t enc_s(input logic [11:0] imm, input core_pkg::reg_addr_t rs2);
  return {imm[11:5], rs2, 5'd1, 3'b010, imm[4:0], core_pkg::OPC_STORE};
endfunction

function automatic core_pkg::xlen_t enc_b(input logic [12:0] imm, input core_pkg::reg_addr_t rs1,
                                          input core_pkg::reg_addr_t rs2, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], core_pkg::OPC_BRANCH};
endfunction

function automatic core_pkg::xlen_t enc_j(input logic [20:0] imm, input core_pkg::reg_addr_t rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, core_pkg::OPC_JAL};
endfunction

// ====================
// program builder
// ====================
task automatic emit(input core_pkg::xlen_t w);
  image[10'(n_words)] = w;
  n_words++;
endtask

task automatic store_reg(input core_pkg::reg_addr_t r);
  emit(enc_s(12'(4 * ($urandom % 16)), r));
endtask

task automatic build_program();
  int                  kind;
  int                  skip;
  logic [2:0]          f3;
  logic [6:0]          f7;
  core_pkg::reg_addr_t rd;
  core_pkg::reg_addr_t ra;
  core_pkg::reg_addr_t rb;
  n_words = 0;
  // x1 holds the data window base for the whole program
  emit(enc_i(12'h400, 5'd0, 3'b000, 5'd1, core_pkg::OPC_OP_IMM));
  while (n_words < PROG_LEN - 6) begin
    kind = int'($urandom % 6);
    skip = 1 + int'($urandom % 3);
    rd   = 5'(2 + $urandom % 30);
    ra   = 5'($urandom);
    rb   = 5'($urandom);
    f3   = 3'($urandom);
    f7   = ((f3 == 3'b000 || f3 == 3'b101) && $urandom % 2 == 0) ? 7'h20 : 7'h00;
    case (kind)
      0: emit(enc_r(f7, rb, ra, f3, rd));
      1: emit(enc_i(12'($urandom), ra, f3, rd, core_pkg::OPC_OP_IMM));
      2: emit({20'($urandom), rd, core_pkg::OPC_LUI});
      3: emit(enc_i(12'(4 * ($urandom % 16)), 5'd1, 3'b010, rd, core_pkg::OPC_LOAD));
      4: begin
        // few registers, so equal operands come up often
        ra = 5'(2 + $urandom % 4);
        rb = ($urandom % 2 == 0) ? ra : 5'(2 + $urandom % 4);
        emit(enc_b(13'(4 * (skip + 1)), ra, rb, 3'($urandom % 2)));
        repeat (skip) store_reg(5'($urandom));
      end
      default: begin
        emit(enc_j(21'(4 * (skip + 1)), rd));
        repeat (skip) store_reg(5'($urandom));
      end
    endcase
    // every result and link value goes out through a store
    if (kind != 4) begin
      store_reg(rd);
    end
  end
  while (n_words < PROG_LEN) begin
    emit(core_pkg::NOP_INSTR);
  end
  emit(enc_j(21'd0, 5'd0));
endtask

// ====================
// reference model
// ====================
function automatic core_pkg::xlen_t alu(input logic [2:0] f3, input logic alt,
                                        input core_pkg::xlen_t a, input core_pkg::xlen_t b);
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return {31'b0, $signed(a) < $signed(b)};
    3'b100:  return a ^ b;
    3'b101:  return alt ? core_pkg::xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

task automatic run_model();
  core_pkg::xlen_t x [32];
  core_pkg::xlen_t pc;
  core_pkg::xlen_t w;
  core_pkg::xlen_t a;
  core_pkg::xlen_t b;
  core_pkg::xlen_t nxt;
  core_pkg::xlen_t ea;
  for (int i = 0; i < 32; i++) begin
    x[5'(i)] = '0;
  end
  ref_mem = image;
  pc = core_pkg::RESET_PC;
  model_steps = 0;
  while (pc != HALT_ADDR && model_steps <= PROG_LEN) begin
    w   = ref_mem[pc[11:2]];
    a   = x[w[19:15]];
    b   = x[w[24:20]];
    nxt = pc + 32'd4;
    case (w[6:0])
      core_pkg::OPC_OP: begin
        if (w[14:12] != 3'b011) begin
          x[w[11:7]] = alu(w[14:12], w[30], a, b);
        end
      end
      core_pkg::OPC_OP_IMM: begin
        // slli, srli, srai and sltiu are outside the subset
        if (w[14:12] == 3'b111 || !w[12]) begin
          x[w[11:7]] = alu(w[14:12], 1'b0, a, {{20{w[31]}}, w[31:20]});
        end
      end
      core_pkg::OPC_LUI: x[w[11:7]] = {w[31:12], 12'b0};
      core_pkg::OPC_LOAD: begin
        if (w[14:12] == 3'b010) begin
          ea = a + {{20{w[31]}}, w[31:20]};
          x[w[11:7]] = ref_mem[ea[11:2]];
        end
      end
      core_pkg::OPC_STORE: begin
        if (w[14:12] == 3'b010) begin
          ea = a + {{20{w[31]}}, w[31:25], w[11:7]};
          ref_mem[ea[11:2]] = b;
          exp_addr.push_back({ea[31:2], 2'b00});
          exp_data.push_back(b);
        end
      end
      core_pkg::OPC_BRANCH: begin
        if ((w[14:12] == 3'b000 && a == b) || (w[14:12] == 3'b001 && a != b)) begin
          nxt = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      core_pkg::OPC_JAL: begin
        x[w[11:7]] = pc + 32'd4;
        nxt = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      default: ;
    endcase
    x[0] = '0;
    pc = nxt;
    model_steps++;
  end
endtask

`endif

//--- tests/tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

  localparam int              MEM_WORDS     = 1024;
  localparam int              PROG_LEN      = 160;
  localparam int              MAX_WAIT      = 3;
  localparam logic [31:0]     SEED          = 32'hd846_5d53;
  localparam core_pkg::xlen_t HALT_ADDR     = 32'(4 * PROG_LEN);
  localparam int              TIMEOUT_CYCLES = 40 * PROG_LEN + 1000;

  logic            clk;
  logic            reset_i;
  logic            psel_o;
  logic            penable_o;
  logic            pwrite_o;
  core_pkg::xlen_t paddr_o;
  core_pkg::xlen_t pwdata_o;
  core_pkg::xlen_t prdata = '0;
  logic            pready = 1'b0;

  // initial image, slave memory and model memory
  core_pkg::xlen_t image   [MEM_WORDS];
  core_pkg::xlen_t mem     [MEM_WORDS];
  core_pkg::xlen_t ref_mem [MEM_WORDS];
  core_pkg::xlen_t exp_addr [$];
  core_pkg::xlen_t exp_data [$];

  int              n_words;
  int              model_steps;
  int              wait_left;
  int              wr_count;
  int              halt_fetches;
  int              reset_errs;
  int              proto_errs;
  int              store_errs;
  int              done_errs;
  int              tests_run;
  int              tests_failed;
  int              total_errs;
  bit              reset_d;
  bit              first_seen;
  bit              prev_setup;
  bit              prev_wait;
  bit              hold_write;
  core_pkg::xlen_t hold_addr;
  core_pkg::xlen_t hold_wdata;

  `include "rv_model.svh"

  rv_core u_rv_core (
    .clk(clk), .reset_i(reset_i),
    .psel_o(psel_o), .penable_o(penable_o), .pwrite_o(pwrite_o),
    .paddr_o(paddr_o), .pwdata_o(pwdata_o), .prdata_i(prdata), .pready_i(pready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ====================
  // checks and reporting
  // ====================
  task automatic check_word(input core_pkg::xlen_t expected, input core_pkg::xlen_t actual,
                            input string name, inout int errs);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      errs++;
    end
  endtask

  task automatic check_addr(input core_pkg::xlen_t expected, input core_pkg::xlen_t actual,
                            inout int errs);
    if (actual !== expected) begin
      $display("Error at %0t ns: paddr_o expected %h, got %h", $time, expected, actual);
      errs++;
    end
  endtask

  task automatic report_fault(input string msg, inout int errs);
    $display("Error at %0t ns: %s", $time, msg);
    errs++;
  endtask

  task automatic report_test(input string name, input int errs);
    tests_run++;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, errs);
    end
  endtask

  task automatic record_transfer();
    if (!first_seen) begin
      first_seen = 1'b1;
      if (pwrite_o) begin
        report_fault("first transfer after reset is a write", reset_errs);
      end
      check_addr(core_pkg::RESET_PC, paddr_o, reset_errs);
      report_test("reset", reset_errs);
    end
    if (pwrite_o) begin
      if (wr_count < exp_addr.size()) begin
        check_addr(exp_addr[wr_count], paddr_o, store_errs);
        check_word(exp_data[wr_count], pwdata_o, "pwdata_o", store_errs);
      end else begin
        report_fault("write beyond the stores of the model", store_errs);
      end
      wr_count++;
    end else if (paddr_o == HALT_ADDR) begin
      halt_fetches++;
    end
  endtask

  // ====================
  // apb slave memory
  // ====================
  always @(posedge clk) begin
    if (reset_i) begin
      mem = image;
      wait_left = 0;
      pready <= 1'b0;
    end else begin
      if (psel_o && penable_o && pready && pwrite_o) begin
        mem[paddr_o[11:2]] = pwdata_o;
      end
      if (psel_o && !penable_o) begin
        wait_left = int'($urandom % (MAX_WAIT + 1));
      end else if (psel_o && penable_o && !pready) begin
        wait_left = wait_left - 1;
      end
      if (psel_o && !(penable_o && pready) && wait_left == 0) begin
        pready <= 1'b1;
        prdata <= mem[paddr_o[11:2]];
      end else begin
        pready <= 1'b0;
      end
    end
  end

  // protocol and transfer monitor
  always @(posedge clk) begin
    if (reset_d && (psel_o !== 1'b0 || penable_o !== 1'b0)) begin
      report_fault("psel_o or penable_o high in or right after reset", reset_errs);
    end
    if (!reset_i) begin
      if (prev_setup && !(psel_o && penable_o)) begin
        report_fault("setup cycle not followed by an access cycle", proto_errs);
      end
      if (psel_o && !penable_o) begin
        if (prev_wait) begin
          report_fault("new setup cycle started during an access", proto_errs);
        end
        hold_addr  = paddr_o;
        hold_write = pwrite_o;
        hold_wdata = pwdata_o;
      end else if (psel_o && penable_o) begin
        if (!prev_setup && !prev_wait) begin
          report_fault("access cycle without a setup cycle", proto_errs);
        end
        check_addr(hold_addr, paddr_o, proto_errs);
        check_word({31'b0, hold_write}, {31'b0, pwrite_o}, "pwrite_o", proto_errs);
        if (hold_write) begin
          check_word(hold_wdata, pwdata_o, "pwdata_o", proto_errs);
        end
      end
      if (psel_o && penable_o && pready) begin
        record_transfer();
      end
      prev_setup = psel_o && !penable_o;
      prev_wait  = psel_o && penable_o && !pready;
    end
    reset_d = reset_i;
  end

  // ====================
  // main sequence
  // ====================
  initial begin
    void'($urandom(SEED));
    reset_i = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      image[10'(i)] = (32'(i) * 32'h9e37_79b9) ^ 32'h3c5a_0f17;
    end
    build_program();
    run_model();
    $display("model: %0d instructions, %0d stores", model_steps, exp_addr.size());
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;
    while (halt_fetches < 2) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    report_test("protocol", proto_errs);
    report_test("stores", store_errs);
    check_word(32'(exp_addr.size()), 32'(wr_count), "write count", done_errs);
    report_test("completion", done_errs);
    total_errs = reset_errs + proto_errs + store_errs + done_errs;
    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
    if (total_errs == 0 && tests_failed == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog sized from the program length
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("watchdog: halt not reached within %0d cycles", TIMEOUT_CYCLES);
    $display("summary: %0d tests, %0d failed, %0d writes seen", tests_run, tests_failed,
             wr_count);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
